// File: Bender.yml
package:
  name: cache

sources:
  - verilog/cache_pkg.sv
  - verilog/cache_way_if.sv
  - verilog/sync_ram.sv
  - verilog/cache_way.sv
  - verilog/write_buffer.sv
  - verilog/cache_ctrl.sv
  - verilog/cache_top.sv
  - target: simulation
    files:
      - sim/bus_mem_model.sv
      - sim/cache_tb.sv

// File: cache.f
verilog/cache_pkg.sv
verilog/cache_way_if.sv
verilog/sync_ram.sv
verilog/cache_way.sv
verilog/write_buffer.sv
verilog/cache_ctrl.sv
verilog/cache_top.sv
sim/bus_mem_model.sv
sim/cache_tb.sv

// File: sim/bus_mem_model.sv
`timescale 1ns/1ps
`default_nettype none

module bus_mem_model (
    input  wire                      clk,
    input  wire  integer             max_delay,
    input  wire                      rd_req,
    input  wire  cache_pkg::addr_t   rd_addr,
    output logic                     rd_rdy,
    output logic                     ret_valid,
    output logic                     ret_last,
    output cache_pkg::word_t         ret_data,
    input  wire                      wr_req,
    input  wire  cache_pkg::addr_t   wr_addr,
    input  wire  cache_pkg::line_t   wr_data,
    output logic                     wr_rdy,
    output int                       reads,
    output int                       writes,
    output cache_pkg::addr_t         last_rd_addr,
    output cache_pkg::addr_t         last_wb_addr,
    output cache_pkg::line_t         last_wb_data
);

    localparam int MEM_WORDS = 8192;   // byte addresses below 0x8000

    cache_pkg::word_t mem [MEM_WORDS];
    cache_pkg::addr_t base;
    integer           seed;

    function automatic cache_pkg::word_t fill_word(input cache_pkg::addr_t a);
        return {a[15:0], a[31:16]} ^ ~a ^ 32'h3c5a_0f96;
    endfunction

    function automatic int pick_delay(input int limit);
        return $unsigned($random(seed)) % (limit + 1);
    endfunction

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    initial begin
        seed = 32'hc6fd;
        rd_rdy = 1'b0;
        wr_rdy = 1'b0;
        ret_valid = 1'b0;
        ret_last = 1'b0;
        ret_data = '0;
        reads = 0;
        writes = 0;
        last_rd_addr = '0;
        last_wb_addr = '0;
        last_wb_data = '0;
        for (int i = 0; i < MEM_WORDS; i++)
            mem[i] = fill_word(i * 4);
        forever begin
            @(negedge clk);
            if (wr_req) begin
                repeat (pick_delay(max_delay)) next_cycle();
                next_cycle();
                wr_rdy = 1'b1;
                last_wb_addr = wr_addr;   // held by the cache until wr_rdy
                last_wb_data = wr_data;
                next_cycle();
                wr_rdy = 1'b0;
                for (int b = 0; b < cache_pkg::NUM_BANKS; b++)
                    mem[last_wb_addr[14:2] + b] = last_wb_data[b*32 +: 32];
                writes++;
            end else if (rd_req) begin
                repeat (pick_delay(max_delay)) next_cycle();
                next_cycle();
                rd_rdy = 1'b1;
                base = rd_addr;
                last_rd_addr = rd_addr;
                next_cycle();
                rd_rdy = 1'b0;
                reads++;
                // beats in bank order with short random gaps
                for (int b = 0; b < cache_pkg::NUM_BANKS; b++) begin
                    repeat (pick_delay(max_delay / 4)) next_cycle();
                    ret_valid = 1'b1;
                    ret_last = (b == cache_pkg::NUM_BANKS - 1);
                    ret_data = mem[base[14:2] + b];
                    next_cycle();
                    ret_valid = 1'b0;
                    ret_last = 1'b0;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: sim/cache_tb.sv
`timescale 1ns/1ps
`default_nettype none

module cache_tb;

    localparam longint WATCHDOG_NS = 300 * 80 * 40;   // requests x cycles x period
    localparam int     MEM_WORDS   = 8192;

    logic clk = 1'b0;
    logic reset;
    logic valid;
    logic op;
    cache_pkg::index_t  index;
    cache_pkg::tag_t    tag;
    cache_pkg::offset_t offset;
    cache_pkg::strb_t   wstrb;
    cache_pkg::word_t   wdata;
    logic addr_ok;
    logic data_ok;
    cache_pkg::word_t   rdata;
    logic rd_req;
    logic rd_rdy;
    logic ret_valid;
    logic ret_last;
    logic wr_req;
    logic wr_rdy;
    cache_pkg::addr_t   rd_addr;
    cache_pkg::addr_t   wr_addr;
    cache_pkg::word_t   ret_data;
    cache_pkg::line_t   wr_data;

    int bus_delay;
    int reads;
    int writes;
    cache_pkg::addr_t   last_rd_addr;
    cache_pkg::addr_t   last_wb_addr;
    cache_pkg::line_t   last_wb_data;

    // reference model of memory as the cpu sees it, plus tags, dirty bits and lfsr
    cache_pkg::word_t   shadow [MEM_WORDS];
    cache_pkg::tag_t    tags [2][cache_pkg::NUM_SETS];
    logic               valids [2][cache_pkg::NUM_SETS];
    logic               dirtys [2][cache_pkg::NUM_SETS];
    logic [2:0]         lfsr;
    int                 exp_reads;
    int                 exp_writes;
    cache_pkg::addr_t   exp_rd_addr;
    cache_pkg::addr_t   exp_wb_addr;
    cache_pkg::line_t   exp_wb_line;
    int                 errors;
    int                 checks;
    integer             seed;

    cache_top uut (
        .clk (clk), .reset (reset), .valid (valid), .op (op),
        .index (index), .tag (tag), .offset (offset), .wstrb (wstrb), .wdata (wdata),
        .addr_ok (addr_ok), .data_ok (data_ok), .rdata (rdata),
        .rd_req (rd_req), .rd_addr (rd_addr), .rd_rdy (rd_rdy),
        .ret_valid (ret_valid), .ret_last (ret_last), .ret_data (ret_data),
        .wr_req (wr_req), .wr_addr (wr_addr), .wr_data (wr_data), .wr_rdy (wr_rdy)
    );

    bus_mem_model mem_model (
        .clk (clk), .max_delay (bus_delay),
        .rd_req (rd_req), .rd_addr (rd_addr), .rd_rdy (rd_rdy),
        .ret_valid (ret_valid), .ret_last (ret_last), .ret_data (ret_data),
        .wr_req (wr_req), .wr_addr (wr_addr), .wr_data (wr_data), .wr_rdy (wr_rdy),
        .reads (reads), .writes (writes), .last_rd_addr (last_rd_addr),
        .last_wb_addr (last_wb_addr), .last_wb_data (last_wb_data)
    );

    always #20 clk = ~clk;

    function automatic cache_pkg::word_t fill_word(input cache_pkg::addr_t a);
        return {a[15:0], a[31:16]} ^ ~a ^ 32'h3c5a_0f96;
    endfunction

    function automatic logic [2:0] lfsr_step(input logic [2:0] s);
        return {s[0], s[2] ^ s[0], s[1]};
    endfunction

    task automatic check(input string name, input logic [127:0] got, input logic [127:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL t=%0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    // valid once the cache takes a new request, so earlier bus work is over
    task automatic check_bus();
        check("bus read count", reads, exp_reads);
        check("bus write count", writes, exp_writes);
        check("rd_addr", last_rd_addr, exp_rd_addr);
        check("wr_addr", last_wb_addr, exp_wb_addr);
        check("wr_data", last_wb_data, exp_wb_line);
    endtask

    // updates the model for one request and returns the word a read should see
    function automatic cache_pkg::word_t predict(input logic wr, input cache_pkg::addr_t a,
                                                 input cache_pkg::strb_t s,
                                                 input cache_pkg::word_t d);
        cache_pkg::index_t idx;
        cache_pkg::tag_t   t;
        cache_pkg::addr_t  vbase;
        cache_pkg::word_t  w;
        int                hit_way;
        logic              v;
        idx = a[11:4];
        t = a[31:12];
        hit_way = -1;
        for (int k = 0; k < 2; k++)
            if (valids[k][idx] && tags[k][idx] == t)
                hit_way = k;
        if (hit_way < 0) begin
            v = lfsr[0];
            if (valids[v][idx] && dirtys[v][idx]) begin
                vbase = {tags[v][idx], idx, 4'h0};
                exp_writes++;
                exp_wb_addr = vbase;
                for (int b = 0; b < cache_pkg::NUM_BANKS; b++)
                    exp_wb_line[b*32 +: 32] = shadow[vbase[14:2] + b];
            end
            exp_reads++;
            exp_rd_addr = {t, idx, 4'h0};
            tags[v][idx] = t;
            valids[v][idx] = 1'b1;
            dirtys[v][idx] = wr;
            lfsr = lfsr_step(lfsr);
        end else if (wr) begin
            dirtys[hit_way][idx] = 1'b1;
        end
        w = shadow[a[14:2]];
        if (wr) begin
            for (int i = 0; i < 4; i++)
                if (s[i])
                    w[i*8 +: 8] = d[i*8 +: 8];
            shadow[a[14:2]] = w;
        end
        return w;
    endfunction

    task automatic drive_addr(input cache_pkg::addr_t a);
        tag = a[31:12];
        index = a[11:4];
        offset = a[3:0];
    endtask

    // one request at a time, entered and left just after a rising edge
    task automatic access(input logic wr, input cache_pkg::addr_t a,
                          input cache_pkg::strb_t s, input cache_pkg::word_t d);
        cache_pkg::word_t exp;
        valid = 1'b1;
        op = wr;
        wstrb = s;
        wdata = d;
        drive_addr(a);
        @(negedge clk);
        while (!addr_ok)
            @(negedge clk);
        check_bus();
        exp = predict(wr, a, s, d);
        @(posedge clk);
        #1 valid = 1'b0;
        @(negedge clk);
        while (!data_ok)
            @(negedge clk);
        if (wr == cache_pkg::OP_READ)
            check("rdata", rdata, exp);
        @(posedge clk);
        #1;
    endtask

    // keeps valid high so reads overlap with the lookup of the one before
    task automatic read_burst(input cache_pkg::addr_t base);
        cache_pkg::word_t expq [$];
        int sent;
        int got;
        int reads0;
        sent = 0;
        got = 0;
        reads0 = 0;
        valid = 1'b1;
        op = cache_pkg::OP_READ;
        wstrb = 4'h0;
        drive_addr(base);
        while (got < cache_pkg::NUM_BANKS) begin
            @(negedge clk);
            if (data_ok) begin
                check("rdata", rdata, expq.pop_front());
                got++;
            end
            if (valid && addr_ok) begin
                if (sent == 0) begin
                    check_bus();
                    reads0 = reads;
                end
                expq.push_back(predict(cache_pkg::OP_READ, base + sent * 4, 4'h0, '0));
                sent++;
            end
            @(posedge clk);
            #1;
            if (sent == cache_pkg::NUM_BANKS)
                valid = 1'b0;
            else
                drive_addr(base + sent * 4);
        end
        check("bus read count", reads, reads0);   // all hits
    endtask

    task automatic read_miss_after_reset();
        access(cache_pkg::OP_READ, 32'h0000_1234, 4'h0, '0);
        check("bus read count", reads, 1);
        check("rd_addr", last_rd_addr, 32'h0000_1230);
        check("bus write count", writes, 0);
    endtask

    task automatic read_hits();
        read_burst(32'h0000_1230);
    endtask

    task automatic write_hit_strobes();
        access(cache_pkg::OP_WRITE, 32'h0000_1238, 4'b0101, 32'haabb_ccdd);
        access(cache_pkg::OP_READ, 32'h0000_1238, 4'h0, '0);
    endtask

    task automatic write_miss();
        access(cache_pkg::OP_WRITE, 32'h0000_2344, 4'b1110, 32'h1122_3344);
        read_burst(32'h0000_2340);
    endtask

    task automatic dirty_eviction();
        int writes0;
        writes0 = writes;
        access(cache_pkg::OP_WRITE, 32'h0000_1564, 4'hf, 32'h0101_a5a5);
        access(cache_pkg::OP_WRITE, 32'h0000_2568, 4'hf, 32'h0202_5a5a);
        access(cache_pkg::OP_WRITE, 32'h0000_356c, 4'hf, 32'h0303_c3c3);   // third tag, one index
        access(cache_pkg::OP_READ, 32'h0000_1564, 4'h0, '0);
        access(cache_pkg::OP_READ, 32'h0000_2568, 4'h0, '0);
        access(cache_pkg::OP_READ, 32'h0000_356c, 4'h0, '0);
        check("write-back seen", writes > writes0, 1'b1);
    endtask

    task automatic back_pressure();
        logic [31:0]       r;
        cache_pkg::index_t idx;
        cache_pkg::addr_t  a;
        bus_delay = 10;
        for (int n = 0; n < 60; n++) begin
            r = $random(seed);
            idx = 8'h23 + 8'h11 * r[3:2];
            a = {17'h0, {1'b0, r[1:0]} + 3'd1, idx, r[5:4], 2'b00};   // tags 1 to 4
            access(r[6], a, r[10:7], $random(seed));
        end
        bus_delay = 2;
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired before the tests finished");
        $display("Simulation FAILED");
        $finish;
    end

    initial begin
        reset = 1'b1;
        valid = 1'b0;
        op = cache_pkg::OP_READ;
        index = '0;
        tag = '0;
        offset = '0;
        wstrb = '0;
        wdata = '0;
        bus_delay = 2;
        errors = 0;
        checks = 0;
        seed = 32'hc6fd;
        lfsr = cache_pkg::LFSR_SEED;
        exp_reads = 0;
        exp_writes = 0;
        exp_rd_addr = '0;
        exp_wb_addr = '0;
        exp_wb_line = '0;
        for (int k = 0; k < 2; k++)
            for (int i = 0; i < cache_pkg::NUM_SETS; i++) begin
                tags[k][i] = '0;
                valids[k][i] = 1'b0;
                dirtys[k][i] = 1'b0;
            end
        for (int i = 0; i < MEM_WORDS; i++)
            shadow[i] = fill_word(i * 4);
        repeat (2) @(posedge clk);
        #1 reset = 1'b0;
        read_miss_after_reset();
        read_hits();
        write_hit_strobes();
        write_miss();
        dirty_eviction();
        back_pressure();
        access(cache_pkg::OP_READ, 32'h0000_1230, 4'h0, '0);   // settles the last bus checks
        $display("errors: %0d in %0d checks", errors, checks);
        if (errors == 0)
            $display("Simulation PASSED");
        else
            $display("Simulation FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog/cache_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module cache_ctrl (
    input  wire                       clk,
    input  wire                       reset,
    input  wire                       valid,
    input  wire                       op,
    input  wire  cache_pkg::index_t   index,
    input  wire  cache_pkg::tag_t     tag,
    input  wire  cache_pkg::offset_t  offset,
    input  wire  cache_pkg::strb_t    wstrb,
    input  wire  cache_pkg::word_t    wdata,
    output logic                      addr_ok,
    output logic                      data_ok,
    output cache_pkg::word_t          rdata,
    output logic                      rd_req,
    output cache_pkg::addr_t          rd_addr,
    input  wire                       rd_rdy,
    input  wire                       ret_valid,
    input  wire                       ret_last,
    input  wire  cache_pkg::word_t    ret_data,
    output logic                      wr_req,
    output cache_pkg::addr_t          wr_addr,
    output cache_pkg::line_t          wr_data,
    input  wire                       wr_rdy,
    cache_way_if.ctrl                 way0,
    cache_way_if.ctrl                 way1
);

    typedef enum logic [2:0] {IDLE, LOOKUP, MISS, REPLACE, REFILL} state_t;

    state_t              state;
    state_t              next_state;

    logic                reg_op;   // request buffer
    cache_pkg::index_t   reg_index;
    cache_pkg::tag_t     reg_tag;
    cache_pkg::bank_t    reg_bank;
    cache_pkg::strb_t    reg_wstrb;
    cache_pkg::word_t    reg_wdata;

    cache_pkg::bank_t    refill_cnt;
    logic [2:0]          lfsr;

    logic                wb_busy;
    logic                wb_way;
    cache_pkg::bank_t    wb_bank;
    cache_pkg::index_t   wb_index;
    cache_pkg::strb_t    wb_strb;
    cache_pkg::word_t    wb_data;

    logic [1:0]          way_hit;
    logic                cache_hit;
    logic                is_store;
    logic                store_hit;
    logic                accept;
    logic                victim;
    logic                victim_dirty;
    logic                in_refill;
    logic                refill_wr;
    logic                first_beat;
    cache_pkg::word_t    hit_word;
    cache_pkg::word_t    refill_word;
    cache_pkg::index_t   ram_addr;
    cache_pkg::word_t    ram_wdata;

    logic [1:0]          way_en;
    logic [1:0]          way_tag_we;
    logic [1:0]          way_dirty_set;
    logic [1:0]          way_dirty_clr;
    cache_pkg::strb_t [1:0][cache_pkg::NUM_BANKS-1:0] way_bank_we;

    assign way_hit[0] = way0.valid && (way0.rd_tag == reg_tag);
    assign way_hit[1] = way1.valid && (way1.rd_tag == reg_tag);
    assign cache_hit  = |way_hit;
    assign is_store   = (reg_op == cache_pkg::OP_WRITE);
    assign store_hit  = (state == LOOKUP) && is_store && cache_hit;
    assign hit_word   = way_hit[1] ? way1.rd_line[reg_bank*32 +: 32]
                                   : way0.rd_line[reg_bank*32 +: 32];

    // nothing new behind a store in lookup or while the buffer writes
    assign accept  = valid && !wb_busy &&
                     ((state == IDLE) || ((state == LOOKUP) && cache_hit && !is_store));
    assign addr_ok = accept;

    always_comb begin
        next_state = state;
        case (state)
            IDLE:    if (accept) next_state = LOOKUP;
            LOOKUP:  next_state = !cache_hit ? MISS : (accept ? LOOKUP : IDLE);
            MISS:    if (!victim_dirty || wr_rdy) next_state = REPLACE;
            REPLACE: if (rd_rdy) next_state = REFILL;
            REFILL:  if (ret_valid && ret_last) next_state = IDLE;
            default: next_state = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset)
            state <= IDLE;
        else
            state <= next_state;
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            reg_op    <= op;
            reg_index <= index;
            reg_tag   <= tag;
            reg_bank  <= offset[3:2];
            reg_wstrb <= wstrb;
            reg_wdata <= wdata;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            refill_cnt <= '0;
            lfsr       <= cache_pkg::LFSR_SEED;
        end else begin
            if (refill_wr)
                refill_cnt <= refill_cnt + 2'd1;   // wraps after the fourth beat
            if (refill_wr && ret_last)
                lfsr <= {lfsr[0], lfsr[2] ^ lfsr[0], lfsr[1]};
        end
    end

    assign victim       = lfsr[0];
    assign victim_dirty = victim ? (way1.valid && way1.dirty) : (way0.valid && way0.dirty);
    assign in_refill    = (state == REFILL);
    assign refill_wr    = in_refill && ret_valid;
    assign first_beat   = refill_wr && (refill_cnt == 2'd0);

    // store miss merges its bytes into the returning word
    always_comb begin
        refill_word = ret_data;
        if (is_store && (refill_cnt == reg_bank)) begin
            for (int i = 0; i < 4; i++) begin
                if (reg_wstrb[i])
                    refill_word[i*8 +: 8] = reg_wdata[i*8 +: 8];
            end
        end
    end

    assign data_ok = ((state == LOOKUP) && (cache_hit || is_store)) ||
                     (refill_wr && !is_store && (refill_cnt == reg_bank));
    assign rdata   = in_refill ? refill_word : hit_word;

    assign rd_req  = (state == REPLACE);
    assign rd_addr = {reg_tag, reg_index, 4'b0000};
    assign wr_req  = (state == MISS) && victim_dirty;
    assign wr_addr = {victim ? way1.rd_tag : way0.rd_tag, reg_index, 4'b0000};
    assign wr_data = victim ? way1.rd_line : way0.rd_line;   // held since lookup

    write_buffer u_wbuf (
        .clk      (clk),
        .reset    (reset),
        .capture  (store_hit),
        .way_in   (way_hit[1]),
        .bank_in  (reg_bank),
        .index_in (reg_index),
        .strb_in  (reg_wstrb),
        .data_in  (reg_wdata),
        .busy     (wb_busy),
        .way      (wb_way),
        .bank     (wb_bank),
        .index    (wb_index),
        .strb     (wb_strb),
        .data     (wb_data)
    );

    always_comb begin
        if (wb_busy)
            ram_addr = wb_index;
        else if (in_refill)
            ram_addr = reg_index;
        else
            ram_addr = index;
    end

    assign ram_wdata = wb_busy ? wb_data : refill_word;

    always_comb begin
        for (int w = 0; w < 2; w++) begin
            way_en[w]        = accept || (wb_busy && (wb_way == w)) || (in_refill && (victim == w));
            way_tag_we[w]    = first_beat && (victim == w);
            way_dirty_set[w] = (store_hit && way_hit[w]) || (way_tag_we[w] && is_store);
            way_dirty_clr[w] = way_tag_we[w] && !is_store;
            for (int b = 0; b < cache_pkg::NUM_BANKS; b++) begin
                if (wb_busy && (wb_way == w) && (wb_bank == b))
                    way_bank_we[w][b] = wb_strb;
                else if (refill_wr && (victim == w) && (refill_cnt == b))
                    way_bank_we[w][b] = 4'hf;
                else
                    way_bank_we[w][b] = 4'h0;
            end
        end
    end

    assign way0.en          = way_en[0];
    assign way0.addr        = ram_addr;
    assign way0.tag_we      = way_tag_we[0];
    assign way0.tag_wdata   = reg_tag;
    assign way0.bank_we     = way_bank_we[0];
    assign way0.bank_wdata  = ram_wdata;
    assign way0.valid_set   = way_tag_we[0];
    assign way0.dirty_index = reg_index;
    assign way0.dirty_set   = way_dirty_set[0];
    assign way0.dirty_clr   = way_dirty_clr[0];

    assign way1.en          = way_en[1];
    assign way1.addr        = ram_addr;
    assign way1.tag_we      = way_tag_we[1];
    assign way1.tag_wdata   = reg_tag;
    assign way1.bank_we     = way_bank_we[1];
    assign way1.bank_wdata  = ram_wdata;
    assign way1.valid_set   = way_tag_we[1];
    assign way1.dirty_index = reg_index;
    assign way1.dirty_set   = way_dirty_set[1];
    assign way1.dirty_clr   = way_dirty_clr[1];

endmodule

`default_nettype wire

// File: verilog/cache_pkg.sv
`default_nettype none

package cache_pkg;

    // address split is tag[31:12], index[11:4], offset[3:0]
    typedef logic [7:0]   index_t;
    typedef logic [19:0]  tag_t;
    typedef logic [3:0]   offset_t;
    typedef logic [1:0]   bank_t;     // offset[3:2]

    typedef logic [31:0]  word_t;
    typedef logic [3:0]   strb_t;
    typedef logic [127:0] line_t;     // bank 0 in the low word
    typedef logic [31:0]  addr_t;

    localparam int NUM_SETS  = 256;
    localparam int NUM_BANKS = 4;

    // op input encoding
    localparam logic OP_READ  = 1'b0;
    localparam logic OP_WRITE = 1'b1;

    localparam logic [2:0] LFSR_SEED = 3'b111;

endpackage

`default_nettype wire

// File: verilog/cache_top.sv
`timescale 1ns/1ps
`default_nettype none

module cache_top (
    input  wire                       clk,
    input  wire                       reset,
    input  wire                       valid,
    input  wire                       op,
    input  wire  cache_pkg::index_t   index,
    input  wire  cache_pkg::tag_t     tag,
    input  wire  cache_pkg::offset_t  offset,
    input  wire  cache_pkg::strb_t    wstrb,
    input  wire  cache_pkg::word_t    wdata,
    output wire                       addr_ok,
    output wire                       data_ok,
    output wire  cache_pkg::word_t    rdata,
    output wire                       rd_req,
    output wire  cache_pkg::addr_t    rd_addr,
    input  wire                       rd_rdy,
    input  wire                       ret_valid,
    input  wire                       ret_last,
    input  wire  cache_pkg::word_t    ret_data,
    output wire                       wr_req,
    output wire  cache_pkg::addr_t    wr_addr,
    output wire  cache_pkg::line_t    wr_data,
    input  wire                       wr_rdy
);

    cache_way_if way0_bus ();
    cache_way_if way1_bus ();

    cache_ctrl u_ctrl (
        .clk       (clk),
        .reset     (reset),
        .valid     (valid),
        .op        (op),
        .index     (index),
        .tag       (tag),
        .offset    (offset),
        .wstrb     (wstrb),
        .wdata     (wdata),
        .addr_ok   (addr_ok),
        .data_ok   (data_ok),
        .rdata     (rdata),
        .rd_req    (rd_req),
        .rd_addr   (rd_addr),
        .rd_rdy    (rd_rdy),
        .ret_valid (ret_valid),
        .ret_last  (ret_last),
        .ret_data  (ret_data),
        .wr_req    (wr_req),
        .wr_addr   (wr_addr),
        .wr_data   (wr_data),
        .wr_rdy    (wr_rdy),
        .way0      (way0_bus.ctrl),
        .way1      (way1_bus.ctrl)
    );

    cache_way u_way0 (
        .clk   (clk),
        .reset (reset),
        .port  (way0_bus.way)
    );

    cache_way u_way1 (
        .clk   (clk),
        .reset (reset),
        .port  (way1_bus.way)
    );

endmodule

`default_nettype wire

// File: verilog/cache_way.sv
`timescale 1ns/1ps
`default_nettype none

module cache_way (
    input wire       clk,
    input wire       reset,
    cache_way_if.way port
);

    localparam int WORD_W = $bits(cache_pkg::word_t);

    logic [cache_pkg::NUM_SETS-1:0] valid_bits;
    logic [cache_pkg::NUM_SETS-1:0] dirty_bits;
    cache_pkg::word_t               bank_q [cache_pkg::NUM_BANKS];

    sync_ram #(.WIDTH($bits(cache_pkg::tag_t))) u_tag_ram (
        .clk   (clk),
        .en    (port.en),
        .we    (port.tag_we),
        .addr  (port.addr),
        .wdata (port.tag_wdata),
        .rdata (port.rd_tag)
    );

    for (genvar g = 0; g < cache_pkg::NUM_BANKS; g++) begin : g_bank
        sync_ram #(.WIDTH(WORD_W)) u_bank_ram (
            .clk   (clk),
            .en    (port.en),
            .we    (port.bank_we[g]),
            .addr  (port.addr),
            .wdata (port.bank_wdata),
            .rdata (bank_q[g])
        );
    end

    always_comb begin
        for (int b = 0; b < cache_pkg::NUM_BANKS; b++)
            port.rd_line[b*WORD_W +: WORD_W] = bank_q[b];
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_bits <= '0;
            dirty_bits <= '0;
        end else begin
            if (port.valid_set)
                valid_bits[port.addr] <= 1'b1;
            if (port.dirty_set)
                dirty_bits[port.dirty_index] <= 1'b1;
            else if (port.dirty_clr)
                dirty_bits[port.dirty_index] <= 1'b0;
        end
    end

    assign port.valid = valid_bits[port.dirty_index];
    assign port.dirty = dirty_bits[port.dirty_index];

endmodule

`default_nettype wire

// File: verilog/cache_way_if.sv
`timescale 1ns/1ps
`default_nettype none

interface cache_way_if;

    logic                                           en;
    cache_pkg::index_t                              addr;
    logic                                           tag_we;
    cache_pkg::tag_t                                tag_wdata;
    cache_pkg::strb_t [cache_pkg::NUM_BANKS-1:0]    bank_we;
    cache_pkg::word_t                               bank_wdata;
    logic                                           valid_set;
    cache_pkg::index_t                              dirty_index;
    logic                                           dirty_set;
    logic                                           dirty_clr;

    cache_pkg::tag_t                                rd_tag;
    cache_pkg::line_t                               rd_line;
    logic                                           valid;   // at dirty_index
    logic                                           dirty;

    modport ctrl (
        output en, addr, tag_we, tag_wdata, bank_we, bank_wdata,
        output valid_set, dirty_index, dirty_set, dirty_clr,
        input  rd_tag, rd_line, valid, dirty
    );

    modport way (
        input  en, addr, tag_we, tag_wdata, bank_we, bank_wdata,
        input  valid_set, dirty_index, dirty_set, dirty_clr,
        output rd_tag, rd_line, valid, dirty
    );

endinterface

`default_nettype wire

// File: verilog/sync_ram.sv
`timescale 1ns/1ps
`default_nettype none

module sync_ram #(
    parameter  int WIDTH = 32,
    localparam int STRB  = (WIDTH % 8 == 0) ? WIDTH / 8 : 1,
    localparam int LANE  = WIDTH / STRB
) (
    input  wire                     clk,
    input  wire                     en,
    input  wire  [STRB-1:0]         we,
    input  wire  cache_pkg::index_t addr,
    input  wire  [WIDTH-1:0]        wdata,
    output logic [WIDTH-1:0]        rdata
);

    logic [WIDTH-1:0] mem [cache_pkg::NUM_SETS];

    always_ff @(posedge clk) begin
        if (en) begin
            for (int i = 0; i < STRB; i++) begin
                if (we[i])
                    mem[addr][i*LANE +: LANE] <= wdata[i*LANE +: LANE];
            end
            rdata <= mem[addr];   // read first, old contents
        end
    end

endmodule

`default_nettype wire

// File: verilog/write_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module write_buffer (
    input  wire                      clk,
    input  wire                      reset,
    input  wire                      capture,
    input  wire                      way_in,
    input  wire  cache_pkg::bank_t   bank_in,
    input  wire  cache_pkg::index_t  index_in,
    input  wire  cache_pkg::strb_t   strb_in,
    input  wire  cache_pkg::word_t   data_in,
    output logic                     busy,
    output logic                     way,
    output cache_pkg::bank_t         bank,
    output cache_pkg::index_t        index,
    output cache_pkg::strb_t         strb,
    output cache_pkg::word_t         data
);

    typedef enum logic {WB_IDLE, WB_WRITE} wb_state_t;

    wb_state_t state;
    wb_state_t next_state;

    // a capture while writing simply reloads the entry
    assign next_state = capture ? WB_WRITE : WB_IDLE;

    always_ff @(posedge clk) begin
        if (reset)
            state <= WB_IDLE;
        else
            state <= next_state;
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            way   <= way_in;
            bank  <= bank_in;
            index <= index_in;
            strb  <= strb_in;
            data  <= data_in;
        end
    end

    assign busy = (state == WB_WRITE);   // one write cycle per entry

endmodule

`default_nettype wire
